// ==== hdl/sec_cache_config.svh ====
`ifndef SEC_CACHE_CONFIG_SVH
`define SEC_CACHE_CONFIG_SVH

// Bus widths
`define SC_ADDR_BITS 32
`define SC_DATA_BITS 32
`define SC_LINE_BITS 128

// Direct-mapped geometry
`define SC_LINES 8

// Address split derived from the widths above
`define SC_BYTE_OFF_BITS ($clog2(`SC_DATA_BITS / 8))
`define SC_WORD_OFF_BITS ($clog2(`SC_LINE_BITS / `SC_DATA_BITS))
`define SC_LINE_OFF_BITS (`SC_BYTE_OFF_BITS + `SC_WORD_OFF_BITS)
`define SC_INDEX_BITS ($clog2(`SC_LINES))
`define SC_TAG_BITS (`SC_ADDR_BITS - `SC_LINE_OFF_BITS - `SC_INDEX_BITS)

// Special addresses
`define SC_DIRECT_ADDR 32'h0000_0000
`define SC_CTRL_ADDR 32'h0000_0004

// Everything below this address is cacheable out of reset
`define SC_RESET_BOUNDARY 32'hc000

`endif

// ==== hdl/sec_cache_pkg.sv ====
`include "sec_cache_config.svh"

package sec_cache_pkg;

	// How a request is routed once it has been classified
	typedef enum logic [1:0] {
		CLASS_DIRECT,
		CLASS_CACHED,
		CLASS_CTRL,
		CLASS_REFUSED
	} req_class_e;

	// ------------------------------------------------------------------
	// Processor side
	// ------------------------------------------------------------------

	typedef struct packed {
		logic                     write;
		logic [`SC_ADDR_BITS-1:0] addr;
		logic [`SC_DATA_BITS-1:0] data;
	} proc_req_t;

	typedef struct packed {
		logic                     write;
		logic [`SC_DATA_BITS-1:0] data;
	} proc_resp_t;

	// ------------------------------------------------------------------
	// Between stages
	// ------------------------------------------------------------------

	typedef struct packed {
		req_class_e               cls;
		logic                     write;
		logic [`SC_ADDR_BITS-1:0] addr;
		logic [`SC_DATA_BITS-1:0] data;
		logic                     domain;
	} stage_item_t;

	// Served means the response word is already known
	typedef struct packed {
		stage_item_t              req;
		logic                     served;
		logic [`SC_DATA_BITS-1:0] hit_data;
	} mem_item_t;

	// ------------------------------------------------------------------
	// Memory side
	// ------------------------------------------------------------------

	typedef struct packed {
		logic                     write;
		logic [`SC_ADDR_BITS-1:0] addr;
		logic [`SC_DATA_BITS-1:0] data;
	} mem_req_t;

	typedef struct packed {
		logic [`SC_ADDR_BITS-1:0] addr;
		logic [`SC_LINE_BITS-1:0] line;
	} line_fill_t;

	// Pick the addressed word out of a whole line
	function automatic logic [`SC_DATA_BITS-1:0] line_word(
		input logic [`SC_LINE_BITS-1:0] line,
		input logic [`SC_ADDR_BITS-1:0] addr
	);
		logic [`SC_WORD_OFF_BITS-1:0] woff;
		woff = addr[`SC_BYTE_OFF_BITS +: `SC_WORD_OFF_BITS];
		return line[woff * `SC_DATA_BITS +: `SC_DATA_BITS];
	endfunction

endpackage

// ==== hdl/req_classify.sv ====
`include "sec_cache_config.svh"

module req_classify
	import sec_cache_pkg::*;
(
	input  logic        clk,
	input  logic        reset,

	input  proc_req_t   procreq_msg,
	input  logic        procreq_domain,
	input  logic        procreq_val,
	input  logic        procresp_val,
	output logic        procreq_rdy,

	output stage_item_t item,
	output logic        item_val
);

	logic                     busy;
	logic                     accept;
	logic [`SC_ADDR_BITS-1:0] boundary;
	req_class_e               cls;

	// Blocking front end with one item in flight
	assign procreq_rdy = !busy;
	assign accept      = procreq_val && procreq_rdy;

	// ------------------------------------------------------------------
	// Routing by address
	// ------------------------------------------------------------------

	always_comb begin
		if (procreq_msg.addr == `SC_DIRECT_ADDR) begin
			cls = CLASS_DIRECT;
		end else if (procreq_msg.addr == `SC_CTRL_ADDR) begin
			// Only the privileged domain may move the boundary
			cls = procreq_domain ? CLASS_CTRL : CLASS_REFUSED;
		end else if (boundary > procreq_msg.addr) begin
			cls = CLASS_CACHED;
		end else begin
			cls = CLASS_DIRECT;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy     <= 1'b0;
			item_val <= 1'b0;
			boundary <= `SC_RESET_BOUNDARY;
		end else begin
			item_val <= accept;
			if (accept) begin
				busy <= 1'b1;
			end else if (procresp_val) begin
				busy <= 1'b0;
			end
			if (accept && cls == CLASS_CTRL) begin
				boundary <= procreq_msg.data;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			item.cls    <= cls;
			item.write  <= procreq_msg.write;
			item.addr   <= procreq_msg.addr;
			item.data   <= procreq_msg.data;
			item.domain <= procreq_domain;
		end
	end

	// No second item enters the pipe before the first one is answered
	a_one_in_flight: assert property (@(posedge clk) disable iff (reset)
		item_val |=> !item_val until procresp_val);

endmodule

// ==== hdl/line_cache.sv ====
`include "sec_cache_config.svh"

module line_cache
	import sec_cache_pkg::*;
(
	input  logic        clk,
	input  logic        reset,

	input  stage_item_t item,
	input  logic        item_val,

	input  line_fill_t  fill,
	input  logic        fill_val,

	output mem_item_t   fwd,
	output logic        fwd_val
);

	logic [`SC_LINES-1:0]     valid;
	logic [`SC_TAG_BITS-1:0]  tag_mem  [`SC_LINES];
	logic [`SC_LINE_BITS-1:0] line_mem [`SC_LINES];

	logic [`SC_INDEX_BITS-1:0]    idx;
	logic [`SC_TAG_BITS-1:0]      tag;
	logic [`SC_WORD_OFF_BITS-1:0] woff;
	logic [`SC_INDEX_BITS-1:0]    fill_idx;
	logic [`SC_TAG_BITS-1:0]      fill_tag;
	logic                         cached;
	logic                         hit;
	logic [`SC_DATA_BITS-1:0]     hit_word;
	logic                         miss_wait;

	// ------------------------------------------------------------------
	// Lookup
	// ------------------------------------------------------------------

	assign idx  = item.addr[`SC_LINE_OFF_BITS +: `SC_INDEX_BITS];
	assign tag  = item.addr[`SC_ADDR_BITS-1 -: `SC_TAG_BITS];
	assign woff = item.addr[`SC_BYTE_OFF_BITS +: `SC_WORD_OFF_BITS];

	assign fill_idx = fill.addr[`SC_LINE_OFF_BITS +: `SC_INDEX_BITS];
	assign fill_tag = fill.addr[`SC_ADDR_BITS-1 -: `SC_TAG_BITS];

	assign cached   = item.cls == CLASS_CACHED;
	assign hit      = valid[idx] && tag_mem[idx] == tag;
	assign hit_word = line_word(line_mem[idx], item.addr);

	// ------------------------------------------------------------------
	// Control state
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			valid     <= '0;
			miss_wait <= 1'b0;
			fwd_val   <= 1'b0;
		end else begin
			// A miss is forwarded as refill request and again once served
			fwd_val <= item_val || fill_val;
			if (item_val && cached && !item.write && !hit) begin
				miss_wait <= 1'b1;
			end else if (fill_val) begin
				miss_wait <= 1'b0;
			end
			if (fill_val) begin
				valid[fill_idx] <= 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------
	// Arrays and forwarded item
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (fill_val) begin
			tag_mem[fill_idx]  <= fill_tag;
			line_mem[fill_idx] <= fill.line;
			// fwd still holds the waiting read
			fwd.served   <= 1'b1;
			fwd.hit_data <= line_word(fill.line, fill.addr);
		end else if (item_val) begin
			fwd.req      <= item;
			fwd.served   <= cached && !item.write && hit;
			fwd.hit_data <= hit_word;
			// Write-through with no allocate on a write miss
			if (cached && item.write && hit) begin
				line_mem[idx][woff * `SC_DATA_BITS +: `SC_DATA_BITS] <= item.data;
			end
		end
	end

	// Refill data only comes back for a read that missed
	a_fill_on_miss: assert property (@(posedge clk) disable iff (reset)
		fill_val |-> miss_wait);

endmodule

// ==== hdl/mem_stage.sv ====
`include "sec_cache_config.svh"

module mem_stage
	import sec_cache_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset,

	input  mem_item_t                fwd,
	input  logic                     fwd_val,

	output mem_req_t                 memreq_msg,
	output logic                     memreq_domain,
	output logic                     memreq_val,
	input  logic                     memreq_rdy,

	input  logic [`SC_LINE_BITS-1:0] memresp_line,
	input  logic                     memresp_val,

	output line_fill_t               fill,
	output logic                     fill_val,

	output proc_resp_t               procresp_msg,
	output logic                     procresp_domain,
	output logic                     procresp_val
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_WAIT
	} state_e;

	state_e    state;
	mem_item_t cur;
	logic      answer_now;
	logic      refill;

	// Nothing to fetch for these
	assign answer_now = fwd.served || fwd.req.cls == CLASS_CTRL ||
		fwd.req.cls == CLASS_REFUSED;

	// Unserved cached read means a line refill
	assign refill = cur.req.cls == CLASS_CACHED && !cur.req.write && !cur.served;

	// ------------------------------------------------------------------
	// Memory request held from cur until taken
	// ------------------------------------------------------------------

	assign memreq_val       = state == ST_REQ;
	assign memreq_msg.write = cur.req.write;
	assign memreq_msg.addr  = refill ?
		{cur.req.addr[`SC_ADDR_BITS-1:`SC_LINE_OFF_BITS], {`SC_LINE_OFF_BITS{1'b0}}} :
		cur.req.addr;
	assign memreq_msg.data  = cur.req.data;
	assign memreq_domain    = cur.req.domain;
	assign procresp_domain  = cur.req.domain;

	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= ST_IDLE;
			procresp_val <= 1'b0;
			fill_val     <= 1'b0;
		end else begin
			procresp_val <= 1'b0;
			fill_val     <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (fwd_val && answer_now) begin
						procresp_val <= 1'b1;
					end else if (fwd_val) begin
						state <= ST_REQ;
					end
				end
				ST_REQ: begin
					if (memreq_rdy) begin
						state <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (memresp_val) begin
						state        <= ST_IDLE;
						fill_val     <= refill;
						procresp_val <= !refill;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Response and fill payload
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && fwd_val) begin
			cur                <= fwd;
			procresp_msg.write <= fwd.req.write;
			procresp_msg.data  <= fwd.served ? fwd.hit_data : '0;
		end
		if (state == ST_WAIT && memresp_val) begin
			procresp_msg.data <= cur.req.write ? '0 : line_word(memresp_line, cur.req.addr);
			fill.addr         <= cur.req.addr;
			fill.line         <= memresp_line;
		end
	end

	// The cache forwards the next item only once this stage is free again
	a_fwd_when_idle: assert property (@(posedge clk) disable iff (reset)
		fwd_val |-> state == ST_IDLE);

endmodule

// ==== hdl/sec_cache_top.sv ====
`include "sec_cache_config.svh"

module sec_cache_top
	import sec_cache_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset,

	// Processor request
	input  proc_req_t                procreq_msg,
	input  logic                     procreq_domain,
	input  logic                     procreq_val,
	output logic                     procreq_rdy,

	// Processor response strobe
	output proc_resp_t               procresp_msg,
	output logic                     procresp_domain,
	output logic                     procresp_val,

	// Memory request
	output mem_req_t                 memreq_msg,
	output logic                     memreq_domain,
	output logic                     memreq_val,
	input  logic                     memreq_rdy,

	// Memory response carrying a full line
	input  logic [`SC_LINE_BITS-1:0] memresp_line,
	input  logic                     memresp_val
);

	stage_item_t item;
	logic        item_val;
	mem_item_t   fwd;
	logic        fwd_val;
	line_fill_t  fill;
	logic        fill_val;

	req_classify classify0 (
		.clk            (clk),
		.reset          (reset),
		.procreq_msg    (procreq_msg),
		.procreq_domain (procreq_domain),
		.procreq_val    (procreq_val),
		.procresp_val   (procresp_val),
		.procreq_rdy    (procreq_rdy),
		.item           (item),
		.item_val       (item_val)
	);

	line_cache cache0 (
		.clk      (clk),
		.reset    (reset),
		.item     (item),
		.item_val (item_val),
		.fill     (fill),
		.fill_val (fill_val),
		.fwd      (fwd),
		.fwd_val  (fwd_val)
	);

	mem_stage mem0 (
		.clk             (clk),
		.reset           (reset),
		.fwd             (fwd),
		.fwd_val         (fwd_val),
		.memreq_msg      (memreq_msg),
		.memreq_domain   (memreq_domain),
		.memreq_val      (memreq_val),
		.memreq_rdy      (memreq_rdy),
		.memresp_line    (memresp_line),
		.memresp_val     (memresp_val),
		.fill            (fill),
		.fill_val        (fill_val),
		.procresp_msg    (procresp_msg),
		.procresp_domain (procresp_domain),
		.procresp_val    (procresp_val)
	);

endmodule

// ==== sim/sec_cache_checks.sv ====
`include "sec_cache_config.svh"

module sec_cache_checks
	import sec_cache_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset,
	input  proc_req_t                procreq_msg,
	input  logic                     procreq_domain,
	input  logic                     procreq_val,
	input  logic                     procreq_rdy,
	input  proc_resp_t               procresp_msg,
	input  logic                     procresp_domain,
	input  logic                     procresp_val,
	input  mem_req_t                 memreq_msg,
	input  logic                     memreq_domain,
	input  logic                     memreq_val,
	input  logic                     memreq_rdy,
	output logic                     error_seen
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [`SC_DATA_BITS-1:0] shadow_mem [logic [31:0]];
	logic [`SC_ADDR_BITS-1:0] boundary;
	logic [`SC_LINES-1:0]     tag_valid;
	logic [`SC_TAG_BITS-1:0]  tag_of [`SC_LINES];

	logic                     in_flight;
	logic [`SC_ADDR_BITS-1:0] cur_addr;
	logic [`SC_DATA_BITS-1:0] cur_data;
	logic                     cur_write;
	logic                     cur_domain;
	logic [`SC_DATA_BITS-1:0] exp_data;
	logic [`SC_ADDR_BITS-1:0] exp_mem_addr;
	int                       exp_mem_reqs;
	int                       mem_reqs;

	initial error_seen = 1'b0;

	// Unwritten memory words follow the memory model's pattern
	function automatic logic [31:0] init_word(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ (addr * 32'h9e37_79b1);
	endfunction

	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		if (shadow_mem.exists(addr >> 2)) begin
			return shadow_mem[addr >> 2];
		end
		return init_word({addr[31:2], 2'b00});
	endfunction

	task automatic report_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		error_seen = 1'b1;
	endtask

	task automatic report_failure(input string what);
		$display("Failure at %0t: %s", $time, what);
		error_seen = 1'b1;
	endtask

	// ------------------------------------------------------------------
	// Reference model of the front end
	// ------------------------------------------------------------------

	always @(posedge clk) begin : track_requests
		logic [`SC_ADDR_BITS-1:0]  addr;
		logic [`SC_INDEX_BITS-1:0] idx;
		logic [`SC_TAG_BITS-1:0]   tag;
		logic                      cached;
		logic                      hit;
		addr   = procreq_msg.addr;
		idx    = addr[`SC_LINE_OFF_BITS +: `SC_INDEX_BITS];
		tag    = addr[`SC_ADDR_BITS-1 -: `SC_TAG_BITS];
		cached = addr != `SC_DIRECT_ADDR && addr != `SC_CTRL_ADDR && boundary > addr;
		hit    = cached && tag_valid[idx] && tag_of[idx] == tag;
		if (memreq_val && memreq_rdy) begin
			mem_reqs <= mem_reqs + 1;
		end
		if (reset) begin
			boundary  <= `SC_RESET_BOUNDARY;
			tag_valid <= '0;
			in_flight <= 1'b0;
			mem_reqs  <= 0;
		end else if (procreq_val && procreq_rdy) begin
			in_flight    <= 1'b1;
			cur_addr     <= addr;
			cur_data     <= procreq_msg.data;
			cur_write    <= procreq_msg.write;
			cur_domain   <= procreq_domain;
			mem_reqs     <= 0;
			exp_data     <= addr == `SC_CTRL_ADDR ? '0 : expected_word(addr);
			exp_mem_reqs <= (addr == `SC_CTRL_ADDR || (hit && !procreq_msg.write)) ? 0 : 1;
			// Read misses fetch the whole aligned line
			exp_mem_addr <= (cached && !procreq_msg.write && !hit) ?
				{addr[`SC_ADDR_BITS-1:`SC_LINE_OFF_BITS], {`SC_LINE_OFF_BITS{1'b0}}} : addr;
			if (addr == `SC_CTRL_ADDR) begin
				if (procreq_domain) begin
					boundary <= procreq_msg.data;
				end
			end else if (procreq_msg.write) begin
				shadow_mem[addr >> 2] = procreq_msg.data;
			end
			// No allocate on writes
			if (cached && !procreq_msg.write) begin
				tag_valid[idx] <= 1'b1;
				tag_of[idx]    <= tag;
			end
		end else if (procresp_val) begin
			in_flight <= 1'b0;
		end
	end

	// ------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------

	a_reset_state: assert property (@(posedge clk)
		$fell(reset) |-> procreq_rdy && !procresp_val && !memreq_val)
		else report_value("{procreq_rdy, procresp_val, memreq_val}", 3'b100,
			$sampled({procreq_rdy, procresp_val, memreq_val}));

	a_resp_owned: assert property (@(posedge clk) disable iff (reset)
		procresp_val |-> in_flight)
		else report_failure("response strobe without a request in flight");

	a_one_request: assert property (@(posedge clk) disable iff (reset)
		in_flight |-> !procreq_rdy)
		else report_value("procreq_rdy", 1'b0, $sampled(procreq_rdy));

	a_resp_domain: assert property (@(posedge clk) disable iff (reset)
		procresp_val |-> procresp_domain == cur_domain)
		else report_value("procresp_domain", $sampled(cur_domain), $sampled(procresp_domain));

	a_resp_write: assert property (@(posedge clk) disable iff (reset)
		procresp_val |-> procresp_msg.write == cur_write)
		else report_value("procresp_msg.write", $sampled(cur_write),
			$sampled(procresp_msg.write));

	// Write responses carry data only on the control address
	a_resp_data: assert property (@(posedge clk) disable iff (reset)
		procresp_val && (!cur_write || cur_addr == `SC_CTRL_ADDR) |->
		procresp_msg.data == exp_data)
		else report_value("procresp_msg.data", $sampled(exp_data), $sampled(procresp_msg.data));

	a_mem_count: assert property (@(posedge clk) disable iff (reset)
		procresp_val |-> mem_reqs == exp_mem_reqs)
		else report_value("memory request count", $sampled(exp_mem_reqs), $sampled(mem_reqs));

	a_mem_domain: assert property (@(posedge clk) disable iff (reset)
		memreq_val |-> memreq_domain == cur_domain)
		else report_value("memreq_domain", $sampled(cur_domain), $sampled(memreq_domain));

	a_mem_addr: assert property (@(posedge clk) disable iff (reset)
		memreq_val |-> memreq_msg.addr == exp_mem_addr)
		else report_value("memreq_msg.addr", $sampled(exp_mem_addr), $sampled(memreq_msg.addr));

	a_mem_write: assert property (@(posedge clk) disable iff (reset)
		memreq_val |-> memreq_msg.write == cur_write)
		else report_value("memreq_msg.write", $sampled(cur_write), $sampled(memreq_msg.write));

	a_mem_data: assert property (@(posedge clk) disable iff (reset)
		memreq_val && cur_write |-> memreq_msg.data == cur_data)
		else report_value("memreq_msg.data", $sampled(cur_data), $sampled(memreq_msg.data));

	a_mem_stall: assert property (@(posedge clk) disable iff (reset)
		memreq_val && !memreq_rdy |=>
		memreq_val && $stable(memreq_msg) && $stable(memreq_domain))
		else report_failure("memory request dropped or changed while stalled");

endmodule

// ==== sim/sec_cache_tb.sv ====
`include "sec_cache_config.svh"

module sec_cache_tb
	import sec_cache_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] SEED       = 32'h3fe75e1b;
	localparam int          WAIT_LIMIT = 200;

	logic                     clk;
	logic                     reset;
	proc_req_t                procreq_msg;
	logic                     procreq_domain;
	logic                     procreq_val;
	logic                     procreq_rdy;
	proc_resp_t               procresp_msg;
	logic                     procresp_domain;
	logic                     procresp_val;
	mem_req_t                 memreq_msg;
	logic                     memreq_domain;
	logic                     memreq_val;
	logic                     memreq_rdy;
	logic [`SC_LINE_BITS-1:0] memresp_line;
	logic                     memresp_val;
	logic                     error_seen;

	logic [31:0]              stim_rng;
	logic [31:0]              mem_rng;
	logic [31:0]              mem_words [logic [31:0]];
	int                       resp_wait;
	logic [`SC_ADDR_BITS-1:0] resp_addr;

	sec_cache_top dut0 (.*);

	sec_cache_checks checks0 (.*);

	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] init_word(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ (addr * 32'h9e37_79b1);
	endfunction

	function automatic logic [31:0] stored_word(input logic [31:0] addr);
		if (mem_words.exists(addr >> 2)) begin
			return mem_words[addr >> 2];
		end
		return init_word({addr[31:2], 2'b00});
	endfunction

	task automatic stop_on_failure(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "simulation stopped");
	endtask

	// Holds the request until the DUT takes it
	task automatic send(input logic write, input logic [31:0] addr,
		input logic [31:0] data, input logic domain);
		int   cycles;
		logic taken;
		procreq_msg.write = write;
		procreq_msg.addr  = addr;
		procreq_msg.data  = data;
		procreq_domain    = domain;
		procreq_val       = 1'b1;
		cycles = 0;
		taken  = 1'b0;
		while (!taken && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			taken = procreq_rdy;
			cycles++;
		end
		#1;
		procreq_val = 1'b0;
		if (!taken) begin
			stop_on_failure("request was not accepted in time");
		end
	endtask

	task automatic wait_ready();
		int   cycles;
		logic ready;
		cycles = 0;
		ready  = 1'b0;
		while (!ready && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			ready = procreq_rdy;
			cycles++;
		end
		#1;
		if (!ready) begin
			stop_on_failure("last request was never answered");
		end
	endtask

	task automatic random_ops(input int count);
		logic [31:0] r;
		logic [31:0] addr;
		logic        domain;
		repeat (count) begin
			stim_rng = xorshift32(stim_rng);
			r        = stim_rng;
			domain   = r[17];
			case (r[2:0])
				3'd0: addr = `SC_DIRECT_ADDR;
				3'd1: begin
					// Unprivileged access that must be refused
					addr   = `SC_CTRL_ADDR;
					domain = 1'b0;
				end
				3'd2, 3'd3: addr = (r[20] ? 32'h1_2000 : 32'hc000) + {r[11:8], 2'b00};
				// 16 lines over 8 sets make lines evict each other
				default: addr = 32'h1000 + {r[13:8], 2'b00};
			endcase
			stim_rng = xorshift32(stim_rng);
			send(r[16], addr, stim_rng, domain);
		end
	endtask

	// ------------------------------------------------------------------
	// Memory model with random stalls and late line responses
	// ------------------------------------------------------------------

	always @(posedge clk) begin : memory_model
		logic     take;
		mem_req_t req;
		take = !reset && memreq_val && memreq_rdy;
		req  = memreq_msg;
		#1;
		memresp_val = 1'b0;
		if (take) begin
			if (req.write) begin
				mem_words[req.addr >> 2] = req.data;
			end
			resp_addr = {req.addr[31:4], 4'h0};
			mem_rng   = xorshift32(mem_rng);
			resp_wait = 1 + mem_rng[7:0] % 3;
		end else if (resp_wait > 0) begin
			resp_wait--;
			if (resp_wait == 0) begin
				for (int i = 0; i < `SC_LINE_BITS / `SC_DATA_BITS; i++) begin
					memresp_line[i * 32 +: 32] = stored_word(resp_addr + 4 * i);
				end
				memresp_val = 1'b1;
			end
		end
		mem_rng    = xorshift32(mem_rng);
		memreq_rdy = mem_rng[3:0] > 4'd4;
	end

	initial begin
		clk            = 1'b0;
		reset          = 1'b1;
		procreq_msg    = '0;
		procreq_domain = 1'b0;
		procreq_val    = 1'b0;
		memreq_rdy     = 1'b0;
		memresp_line   = '0;
		memresp_val    = 1'b0;
		resp_wait      = 0;
		resp_addr      = '0;
		stim_rng       = SEED;
		mem_rng        = SEED ^ 32'h9e37_79b9;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		// Miss and hits on one line followed by uncacheable and address 0 reads
		send(1'b0, 32'h1000, '0, 1'b0);
		send(1'b0, 32'h1000, '0, 1'b1);
		send(1'b0, 32'h1008, '0, 1'b0);
		send(1'b0, 32'hc010, '0, 1'b0);
		send(1'b0, 32'hc010, '0, 1'b1);
		send(1'b1, `SC_DIRECT_ADDR, 32'h1234_5678, 1'b1);
		send(1'b0, `SC_DIRECT_ADDR, '0, 1'b0);
		send(1'b0, `SC_DIRECT_ADDR, '0, 1'b1);
		random_ops(200);

		// Domain 0 tries to shrink the boundary
		send(1'b1, `SC_CTRL_ADDR, 32'h0000_0010, 1'b0);
		send(1'b0, `SC_CTRL_ADDR, '0, 1'b0);
		send(1'b0, 32'h1000, '0, 1'b0);
		send(1'b0, 32'h1000, '0, 1'b1);

		// Raising the boundary makes the 0xc000 region cacheable
		send(1'b1, `SC_CTRL_ADDR, 32'h0001_0000, 1'b1);
		send(1'b0, 32'hc010, '0, 1'b0);
		send(1'b0, 32'hc010, '0, 1'b1);
		random_ops(200);

		wait_ready();
		repeat (4) @(posedge clk);
		if (error_seen) begin
			stop_on_failure("checker reported an error");
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

	always @(posedge error_seen) begin
		stop_on_failure("checker reported an error");
	end

endmodule

// ==== filelist.f ====
+incdir+hdl
hdl/sec_cache_pkg.sv
hdl/req_classify.sv
hdl/line_cache.sv
hdl/mem_stage.sv
hdl/sec_cache_top.sv
sim/sec_cache_checks.sv
sim/sec_cache_tb.sv

// ==== Bender.yml ====
package:
  name: sec_cache

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/sec_cache_pkg.sv
      - hdl/req_classify.sv
      - hdl/line_cache.sv
      - hdl/mem_stage.sv
      - hdl/sec_cache_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/sec_cache_checks.sv
      - sim/sec_cache_tb.sv
